//--- vlog.f
+incdir+hw
+incdir+testbench
hw/fxf_num_pkg.sv
hw/fxf_strm_pkg.sv
hw/lead_zero_count.sv
hw/pipe_ctrl.sv
hw/fixed_to_float.sv
hw/fxf_top.sv
testbench/fxf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fixed-to-float testbench with Verilator and run it
# the log is searched for the failure line, any build or run error also fails

set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
	&& verilator --binary --assert --top-module fxf_tb -f vlog.f -Mdir obj_dir -o fxf_sim \
	&& ./obj_dir/fxf_sim 2>&1 | tee sim.log \
	&& ! grep -q "Some tests failed" sim.log \
	&& echo "run_sim: simulation clean" \
	|| { echo "run_sim: simulation reported errors, see sim.log"; exit 1; }

exit 0

//--- testbench/fxf_tb_vectors.svh
`ifndef FXF_TB_VECTORS_SVH
`define FXF_TB_VECTORS_SVH

// columns: user tag, Q16.16 input word, expected IEEE-754 single bits

typedef struct packed {
	logic [7:0]  user;
	logic [31:0] fix;
	logic [31:0] flt;
} vec_t;

localparam int VEC_COUNT = 10;

// ------------------------------
// directed conversion vectors
// ------------------------------
localparam vec_t VEC_TABLE [VEC_COUNT] = '{
	// zero gives +0
	{8'h01, 32'h0000_0000, 32'h0000_0000},
	{8'h02, 32'h0001_0000, 32'h3f80_0000},
	{8'h03, 32'hffff_0000, 32'hbf80_0000},
	{8'h04, 32'h0000_8000, 32'h3f00_0000},
	// smallest step, 2^-16
	{8'h05, 32'h0000_0001, 32'h3780_0000},
	// 32767.99998, truncated instead of rounded up
	{8'h06, 32'h7fff_ffff, 32'h46ff_ffff},
	// most negative, exact
	{8'h07, 32'h8000_0000, 32'hc700_0000},
	{8'h08, 32'hffff_ffff, 32'hb780_0000},
	{8'h09, 32'hfffe_8000, 32'hbfc0_0000},
	{8'h0a, 32'h0064_4000, 32'h42c8_8000}
};

`endif

//--- testbench/fxf_tb.sv
`timescale 1ns/1ps

module fxf_tb
	import fxf_num_pkg::*;
	import fxf_strm_pkg::*;
();

	`include "fxf_tb_vectors.svh"

	localparam int TIMEOUT = 1000;

	// one accepted input waiting for its output
	typedef struct packed {
		logic [7:0]  user;
		logic [31:0] flt;
		int          cyc;
	} pend_t;

	logic      clk;
	logic      rst_n;
	fix_beat_t s_beat;
	logic      s_valid;
	logic      s_ready;
	flt_beat_t m_beat;
	logic      m_valid;
	logic      m_ready;

	logic [31:0] lfsr;
	logic [31:0] s_expect;
	logic        check_lat;
	pend_t       pend_q[$];
	int          cycle = 0;
	int          acc_count = 0;
	int          mon_errs = 0;
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic        stall_prev = 1'b0;
	flt_beat_t   held_beat;

	fxf_top DUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.s_beat  (s_beat),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_beat  (m_beat),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] want, inout int errs);
		if (got !== want) begin
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, want);
			errs++;
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] bits);
		int i;
		bits = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	// expected float by moving the leading one up to bit 31
	function automatic logic [31:0] ref_float(input logic [31:0] fix);
		logic [31:0] norm;
		logic [7:0]  expo;
		norm = fix[31] ? (~fix + 32'd1) : fix;
		// leading one at bit 31 stands for 2^15
		expo = 8'd142;
		if (fix == 32'd0) begin
			return 32'd0;
		end
		while (!norm[31]) begin
			norm = norm << 1;
			expo = expo - 8'd1;
		end
		return {fix[31], expo, norm[30:8]};
	endfunction

	task automatic send_beat(input logic [7:0] user, input logic [31:0] fix,
		input logic [31:0] flt);
		int base;
		int waited;
		base = acc_count;
		waited = 0;
		s_beat.user = user;
		s_beat.value = fix;
		s_expect = flt;
		s_valid = 1'b1;
		while (acc_count == base && waited < TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		s_valid = 1'b0;
		if (acc_count == base) begin
			$display("timeout: input beat with tag %h was never accepted", user);
			errors++;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pend_q.size() != 0 && waited < TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (pend_q.size() != 0) begin
			$display("timeout: %0d accepted beats never came out", pend_q.size());
			errors++;
		end
		// nothing left means nothing may still be offered
		check_val("m_valid", {31'd0, m_valid}, 32'd0, errors);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors + mon_errs != errs_before) begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, name,
				errors + mon_errs - errs_before);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	// ------------------------------
	// monitor and scoreboard
	// ------------------------------
	always @(posedge clk) begin
		pend_t p;
		cycle++;
		if (rst_n && s_valid && s_ready) begin
			pend_q.push_back({s_beat.user, s_expect, cycle});
			acc_count++;
		end
		if (rst_n && m_valid && m_ready) begin
			if (pend_q.size() == 0) begin
				$display("output beat at %0t with no accepted input pending", $time);
				mon_errs++;
			end else begin
				p = pend_q.pop_front();
				check_val("m_beat.user", {24'd0, m_beat.user}, {24'd0, p.user}, mon_errs);
				check_val("m_beat.value", m_beat.value, p.flt, mon_errs);
				if (check_lat) begin
					check_val("latency", cycle - p.cyc, 32'd3, mon_errs);
				end
			end
		end
		// a stalled beat must not move
		if (rst_n && stall_prev) begin
			check_val("m_valid", {31'd0, m_valid}, 32'd1, mon_errs);
			check_val("m_beat.user", {24'd0, m_beat.user}, {24'd0, held_beat.user}, mon_errs);
			check_val("m_beat.value", m_beat.value, held_beat.value, mon_errs);
		end
		stall_prev = rst_n && m_valid && !m_ready;
		held_beat = m_beat;
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		logic [31:0] rnd [408];
		logic [31:0] word;
		logic [31:0] shift;
		int          mark;
		int          start;
		int          i;
		int          k;
		int          spins;
		logic        low_seen;
		logic        done;

		lfsr = 32'hadd7_d31f;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst_n = 1'b0;
		s_beat = '0;
		s_valid = 1'b0;
		s_expect = '0;
		m_ready = 1'b1;
		check_lat = 1'b0;

		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// random words shifted so small exponents show up too
		for (i = 0; i < 408; i++) begin
			draw_bits(32, word);
			draw_bits(5, shift);
			rnd[i] = $signed(word) >>> shift[4:0];
		end

		mark = errors + mon_errs;
		check_val("s_ready", {31'd0, s_ready}, 32'd1, errors);
		check_val("m_valid", {31'd0, m_valid}, 32'd0, errors);
		end_test("reset state", mark);

		mark = errors + mon_errs;
		check_lat = 1'b1;
		for (i = 0; i < VEC_COUNT; i++) begin
			check_val("ref_float", ref_float(VEC_TABLE[i].fix), VEC_TABLE[i].flt, errors);
			send_beat(VEC_TABLE[i].user, VEC_TABLE[i].fix, VEC_TABLE[i].flt);
		end
		wait_drain();
		end_test("table vectors", mark);

		mark = errors + mon_errs;
		start = cycle;
		for (i = 0; i < 200; i++) begin
			send_beat(8'(i), rnd[i], ref_float(rnd[i]));
		end
		// back to back means one acceptance per edge
		check_val("accept cycles", cycle - start, 32'd200, errors);
		wait_drain();
		end_test("random back to back", mark);

		mark = errors + mon_errs;
		check_lat = 1'b0;
		done = 1'b0;
		fork
			begin
				for (i = 0; i < 200; i++) begin
					send_beat(8'(i), rnd[200 + i], ref_float(rnd[200 + i]));
				end
				wait_drain();
				done = 1'b1;
			end
			begin
				spins = 0;
				while (!done && spins < 4 * TIMEOUT) begin
					draw_bits(1, word);
					m_ready = word[0];
					@(posedge clk);
					#1;
					spins++;
				end
				if (!done) begin
					$display("timeout: random back-pressure run did not finish");
					errors++;
				end
			end
		join
		m_ready = 1'b1;
		end_test("random back-pressure", mark);

		mark = errors + mon_errs;
		low_seen = 1'b0;
		m_ready = 1'b0;
		fork
			begin
				for (i = 0; i < 8; i++) begin
					send_beat(8'(192 + i), rnd[400 + i], ref_float(rnd[400 + i]));
				end
			end
			begin
				for (k = 0; k < 10; k++) begin
					@(posedge clk);
					#1;
					if (!s_ready) begin
						low_seen = 1'b1;
					end
				end
				m_ready = 1'b1;
			end
		join
		wait_drain();
		check_val("s_ready low during stall", {31'd0, low_seen}, 32'd1, errors);
		end_test("ten cycle stall", mark);

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
			errors + mon_errs);
		if (tests_failed == 0 && errors + mon_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- hw/fxf_top.sv
`timescale 1ns/1ps

module fxf_top
	import fxf_strm_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// fixed-point stream in
	input  fix_beat_t s_beat,
	input  logic      s_valid,
	output logic      s_ready,

	// float stream out
	output flt_beat_t m_beat,
	output logic      m_valid,
	input  logic      m_ready
);

	fixed_to_float u_fixed_to_float (
		.clk     (clk),
		.rst_n   (rst_n),
		.s_beat  (s_beat),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_beat  (m_beat),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

endmodule

//--- hw/fixed_to_float.sv
`timescale 1ns/1ps

`include "fxf_consts.svh"

module fixed_to_float
	import fxf_num_pkg::*;
	import fxf_strm_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  fix_beat_t s_beat,
	input  logic      s_valid,
	output logic      s_ready,

	output flt_beat_t m_beat,
	output logic      m_valid,
	input  logic      m_ready
);

	// exponent for a leading one at the top magnitude bit
	localparam logic [`FXF_FLT_EXP_W-1:0] EXP_TOP =
		`FXF_FLT_BIAS + `FXF_FIX_W - 1 - `FXF_FIX_FRAC_W;

	typedef struct packed {
		logic [`FXF_USER_W-1:0] user;
		logic                   zero;
		logic                   sign;
		mag_t                   mag;
	} st0_t;

	typedef struct packed {
		logic [`FXF_USER_W-1:0] user;
		logic                   zero;
		logic                   sign;
		clz_t                   clz;
		mag_t                   mag;
	} st1_t;

	logic [`FXF_STAGES-1:0] stage_en;
	logic [`FXF_STAGES-1:0] stage_vld;

	st0_t      st0_q;
	clz_t      st0_clz;
	st1_t      st1_q;
	mag_t      st1_norm;
	flt_beat_t st2_d;
	flt_beat_t st2_q;

	pipe_ctrl u_pipe_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.s_valid   (s_valid),
		.s_ready   (s_ready),
		.sink_beat (st2_q),
		.m_beat    (m_beat),
		.m_valid   (m_valid),
		.m_ready   (m_ready),
		.stage_en  (stage_en),
		.stage_vld (stage_vld)
	);

	// ------------------------------
	// stage 0: sign and magnitude
	// ------------------------------
	always_ff @(posedge clk) begin
		if (stage_en[0] && s_valid) begin
			st0_q.user <= s_beat.user;
			st0_q.zero <= (s_beat.value == '0);
			st0_q.sign <= s_beat.value[`FXF_FIX_W-1];
			// -32768.0 wraps to 2^31, still correct unsigned
			st0_q.mag  <= s_beat.value[`FXF_FIX_W-1] ? mag_t'(-s_beat.value)
			                                         : mag_t'(s_beat.value);
		end
	end

	// ------------------------------
	// stage 1: leading-zero count
	// ------------------------------
	lead_zero_count u_lzc (
		.mag (st0_q.mag),
		.clz (st0_clz)
	);

	always_ff @(posedge clk) begin
		if (stage_en[1] && stage_vld[0]) begin
			st1_q.user <= st0_q.user;
			st1_q.zero <= st0_q.zero;
			st1_q.sign <= st0_q.sign;
			st1_q.clz  <= st0_clz;
			st1_q.mag  <= st0_q.mag;
		end
	end

	// ------------------------------
	// stage 2: exponent and fraction
	// ------------------------------

	// drop the hidden one off the top
	assign st1_norm = st1_q.mag << (st1_q.clz + 1'b1);

	always_comb begin
		st2_d.user       = st1_q.user;
		st2_d.value.frac = st1_norm[`FXF_FIX_W-1 -: `FXF_FLT_FRAC_W];
		if (st1_q.zero) begin
			// always +0
			st2_d.value.sign = 1'b0;
			st2_d.value.exp  = '0;
		end else begin
			st2_d.value.sign = st1_q.sign;
			st2_d.value.exp  = EXP_TOP -
				{{(`FXF_FLT_EXP_W - $bits(clz_t)){1'b0}}, st1_q.clz};
		end
	end

	always_ff @(posedge clk) begin
		if (stage_en[2] && stage_vld[1]) begin
			st2_q <= st2_d;
		end
	end

endmodule

//--- hw/pipe_ctrl.sv
`timescale 1ns/1ps

`include "fxf_consts.svh"

module pipe_ctrl
	import fxf_strm_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   s_valid,
	output logic                   s_ready,

	input  flt_beat_t              sink_beat,
	output flt_beat_t              m_beat,
	output logic                   m_valid,
	input  logic                   m_ready,

	output logic [`FXF_STAGES-1:0] stage_en,
	output logic [`FXF_STAGES-1:0] stage_vld
);

	localparam int LAST = `FXF_STAGES - 1;

	skid_state_t            skid_state;
	flt_beat_t              skid_beat;
	logic [`FXF_STAGES-1:0] vld_q;
	logic                   advance;
	logic                   catch;

	// ------------------------------
	// common stage enable
	// ------------------------------

	// whole pipe moves as one while the skid slot is free
	assign advance   = (skid_state == SKID_EMPTY);
	assign stage_en  = {`FXF_STAGES{advance}};
	assign s_ready   = advance;
	assign stage_vld = vld_q;

	// valid bits shift along with the data
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else if (advance) begin
			vld_q <= {vld_q[LAST-1:0], s_valid};
		end
	end

	// ------------------------------
	// output skid buffer
	// ------------------------------

	// last stage has a beat the sink refuses
	assign catch = advance && vld_q[LAST] && !m_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			skid_state <= SKID_EMPTY;
		end else begin
			case (skid_state)
				SKID_EMPTY: begin
					if (catch) begin
						skid_state <= SKID_FULL;
					end
				end
				SKID_FULL: begin
					if (m_ready) begin
						skid_state <= SKID_EMPTY;
					end
				end
				default: begin
					skid_state <= SKID_EMPTY;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (catch) begin
			skid_beat <= sink_beat;
		end
	end

	// held beat goes out first
	assign m_beat  = (skid_state == SKID_FULL) ? skid_beat : sink_beat;
	assign m_valid = vld_q[LAST] || (skid_state == SKID_FULL);

	// ------------------------------
	// checks
	// ------------------------------

	a_m_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_valid && !m_ready |=> m_valid && $stable(m_beat))
		else $error("pipe_ctrl: m_beat changed during a stall");

	// input side only closes behind a beat the sink turned away
	a_s_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!s_ready |-> $past(m_valid && !m_ready))
		else $error("pipe_ctrl: s_ready low without a refused output beat");

endmodule

//--- hw/lead_zero_count.sv
`timescale 1ns/1ps

`include "fxf_consts.svh"

module lead_zero_count
	import fxf_num_pkg::*;
(
	input  mag_t mag,
	output clz_t clz
);

	// scan upward, the highest set bit wins
	always_comb begin
		clz = clz_t'(`FXF_FIX_W);
		for (int i = 0; i < `FXF_FIX_W; i++) begin
			if (mag[i]) begin
				clz = clz_t'(`FXF_FIX_W - 1 - i);
			end
		end
	end

	// full count only for an all-zero word
	always_comb begin
		a_clz_zero: assert ((clz == clz_t'(`FXF_FIX_W)) == (mag == '0))
			else $error("lead_zero_count: clz %0d for mag %h", clz, mag);
	end

endmodule

//--- hw/fxf_strm_pkg.sv
`include "fxf_consts.svh"

package fxf_strm_pkg;

	import fxf_num_pkg::*;

	// input beat, tag rides along with the value
	typedef struct packed {
		logic [`FXF_USER_W-1:0] user;
		fix_word_t              value;
	} fix_beat_t;

	// output beat
	typedef struct packed {
		logic [`FXF_USER_W-1:0] user;
		float_t                 value;
	} flt_beat_t;

	// output holding register
	typedef enum logic {
		SKID_EMPTY = 1'b0,
		SKID_FULL  = 1'b1
	} skid_state_t;

endpackage

//--- hw/fxf_num_pkg.sv
`include "fxf_consts.svh"

package fxf_num_pkg;

	// ------------------------------
	// fixed side
	// ------------------------------

	// Q16.16, two's complement
	typedef logic signed [`FXF_FIX_W-1:0] fix_word_t;

	// absolute value, wide enough for -32768.0
	typedef logic [`FXF_FIX_W-1:0] mag_t;

	// 0 .. 32, so one bit more than log2 of the width
	typedef logic [$clog2(`FXF_FIX_W+1)-1:0] clz_t;

	// ------------------------------
	// float side
	// ------------------------------

	// IEEE-754 single, msb first
	typedef struct packed {
		logic                       sign;
		logic [`FXF_FLT_EXP_W-1:0]  exp;
		logic [`FXF_FLT_FRAC_W-1:0] frac;
	} float_t;

endpackage

//--- hw/fxf_consts.svh
`ifndef FXF_CONSTS_SVH
`define FXF_CONSTS_SVH

// ------------------------------
// fixed-point input format
// ------------------------------
`define FXF_FIX_INT_W   16
`define FXF_FIX_FRAC_W  16
`define FXF_FIX_W       (`FXF_FIX_INT_W + `FXF_FIX_FRAC_W)

// ------------------------------
// single-precision float format
// ------------------------------
`define FXF_FLT_EXP_W   8
`define FXF_FLT_FRAC_W  23
`define FXF_FLT_BIAS    127

// stream side-band tag
`define FXF_USER_W      8

// sign/mag, clz, assembly
`define FXF_STAGES      3

`endif
